// ==== dramPkg.sv ====
`default_nettype none
// ----------------------------------------
// DRAM subsystem package
// Geometry, queue depth, latency and command codes
// ----------------------------------------
package dramPkg;

	// ----------------------------------------
	// Word geometry
	// ----------------------------------------
	localparam int AddressWidth = 10;
	localparam int DataWidth = 64;
	localparam int ByteWidth = 8;
	// One mask bit per byte lane
	localparam int MaskWidth = DataWidth / ByteWidth;
	localparam int MemoryWords = 1 << AddressWidth;

	// ----------------------------------------
	// Command codes (MIG style)
	// ----------------------------------------
	localparam int CommandWidth = 3;
	localparam logic [CommandWidth-1:0] CmdWrite = 3'd0;
	localparam logic [CommandWidth-1:0] CmdRead = 3'd1;

	// ----------------------------------------
	// Queues, latency, calibration
	// ----------------------------------------
	localparam int QueueDepth = 4;
	localparam int QueuePointerWidth = $clog2(QueueDepth);
	// Count must reach QueueDepth itself
	localparam int QueueCountWidth = $clog2(QueueDepth + 1);
	// Issue to read-data-valid, array register included
	localparam int ReadLatency = 4;
	localparam int ReturnStages = ReadLatency - 1;
	localparam int CalibrationCycles = 16;
	localparam int CalibrationCountWidth = $clog2(CalibrationCycles);

endpackage
`default_nettype wire

// ==== dramIfs.sv ====
`default_nettype none
`timescale 1ns/1ps
// ----------------------------------------
// Internal buses of the DRAM subsystem
// Queue heads toward the scheduler, access to the array
// ----------------------------------------

// Command queue head
interface memCommandIf import dramPkg::*; ();
	logic headValid;
	logic pop;
	logic [CommandWidth-1:0] command;
	logic [AddressWidth-1:0] address;

	modport queue (
		output headValid, command, address,
		input pop
	);
	// Pop only while headValid
	modport scheduler (
		input headValid, command, address,
		output pop
	);
endinterface

// Write data queue head, data and byte mask
interface memWriteIf import dramPkg::*; ();
	logic headValid;
	logic pop;
	logic [DataWidth-1:0] data;
	logic [MaskWidth-1:0] mask;

	modport queue (
		output headValid, data, mask,
		input pop
	);
	modport scheduler (
		input headValid, data, mask,
		output pop
	);
endinterface

// One-cycle access strobe, array always accepts
interface memAccessIf import dramPkg::*; ();
	logic enable;
	logic isWrite;
	logic [AddressWidth-1:0] address;
	logic [DataWidth-1:0] data;
	logic [MaskWidth-1:0] mask;

	modport source (output enable, isWrite, address, data, mask);
	modport sink (input enable, isWrite, address, data, mask);
endinterface
`default_nettype wire

// ==== commandQueue.sv ====
`default_nettype none
`timescale 1ns/1ps
// ----------------------------------------
// Command queue
// Holds command code and address and is ready while not full
// ----------------------------------------
module commandQueue import dramPkg::*; (
	input logic MemoryClock,
	input logic rstN,
	input logic [CommandWidth-1:0] command,
	input logic [AddressWidth-1:0] address,
	input logic valid,
	output logic ready,
	memCommandIf.queue head
);

	// Entry storage
	logic [CommandWidth-1:0] commandSlots [QueueDepth];
	logic [AddressWidth-1:0] addressSlots [QueueDepth];

	logic [QueuePointerWidth-1:0] writePointer;
	logic [QueuePointerWidth-1:0] readPointer;
	logic [QueueCountWidth-1:0] entryCount;
	logic push;

	// Space left means ready
	assign ready = (entryCount != QueueCountWidth'(QueueDepth));
	assign push = valid & ready;

	// Oldest entry at the head
	assign head.headValid = (entryCount != '0);
	assign head.command = commandSlots[readPointer];
	assign head.address = addressSlots[readPointer];

	// ----------------------------------------
	// Pointers and occupancy
	// ----------------------------------------
	always_ff @(posedge MemoryClock or negedge rstN) begin
		if (!rstN) begin
			writePointer <= '0;
			readPointer <= '0;
			entryCount <= '0;
		end else begin
			if (push) begin
				// Wrap at the last slot
				writePointer <= (writePointer == QueuePointerWidth'(QueueDepth - 1)) ?
					'0 : writePointer + 1'b1;
			end
			if (head.pop) begin
				readPointer <= (readPointer == QueuePointerWidth'(QueueDepth - 1)) ?
					'0 : readPointer + 1'b1;
			end
			// Simultaneous push and pop leaves count unchanged
			if (push && !head.pop) entryCount <= entryCount + 1'b1;
			else if (!push && head.pop) entryCount <= entryCount - 1'b1;
		end
	end

	// Entry write
	always_ff @(posedge MemoryClock) begin
		if (push) begin
			commandSlots[writePointer] <= command;
			addressSlots[writePointer] <= address;
		end
	end

endmodule
`default_nettype wire

// ==== writeDataQueue.sv ====
`default_nettype none
`timescale 1ns/1ps
// ----------------------------------------
// Write data queue
// Data beats with their byte masks, ready while not full
// ----------------------------------------
module writeDataQueue import dramPkg::*; (
	input logic MemoryClock,
	input logic rstN,
	input logic [DataWidth-1:0] data,
	input logic [MaskWidth-1:0] mask,
	input logic valid,
	output logic ready,
	memWriteIf.queue head
);

	// Mask stays with its beat
	logic [DataWidth-1:0] dataSlots [QueueDepth];
	logic [MaskWidth-1:0] maskSlots [QueueDepth];

	logic [QueuePointerWidth-1:0] writePointer;
	logic [QueuePointerWidth-1:0] readPointer;
	logic [QueueCountWidth-1:0] entryCount;
	logic push;

	assign ready = (entryCount != QueueCountWidth'(QueueDepth));
	assign push = valid & ready;

	assign head.headValid = (entryCount != '0);
	assign head.data = dataSlots[readPointer];
	assign head.mask = maskSlots[readPointer];

	// ----------------------------------------
	// Pointers and occupancy
	// ----------------------------------------
	always_ff @(posedge MemoryClock or negedge rstN) begin
		if (!rstN) begin
			writePointer <= '0;
			readPointer <= '0;
			entryCount <= '0;
		end else begin
			if (push) begin
				writePointer <= (writePointer == QueuePointerWidth'(QueueDepth - 1)) ?
					'0 : writePointer + 1'b1;
			end
			// Pop driven by the command/data join
			if (head.pop) begin
				readPointer <= (readPointer == QueuePointerWidth'(QueueDepth - 1)) ?
					'0 : readPointer + 1'b1;
			end
			if (push && !head.pop) entryCount <= entryCount + 1'b1;
			else if (!push && head.pop) entryCount <= entryCount - 1'b1;
		end
	end

	always_ff @(posedge MemoryClock) begin
		if (push) begin
			dataSlots[writePointer] <= data;
			maskSlots[writePointer] <= mask;
		end
	end

endmodule
`default_nettype wire

// ==== accessScheduler.sv ====
`default_nettype none
`timescale 1ns/1ps
// ----------------------------------------
// Access scheduler
// Calibration hold-off, write command/data join, issue
// ----------------------------------------
module accessScheduler import dramPkg::*; (
	input logic MemoryClock,
	input logic rstN,
	memCommandIf.scheduler commands,
	memWriteIf.scheduler writes,
	memAccessIf.source access,
	output logic calibrationComplete
);

	logic [CalibrationCountWidth-1:0] calibrationCount;
	logic headIsRead;
	logic headIsWrite;
	logic headIsUnknown;
	logic writeJoined;

	// ----------------------------------------
	// Calibration period after reset
	// ----------------------------------------
	always_ff @(posedge MemoryClock or negedge rstN) begin
		if (!rstN) begin
			calibrationCount <= '0;
			calibrationComplete <= 1'b0;
		end else if (!calibrationComplete) begin
			// Last count sets the flag, then counting stops
			if (calibrationCount == CalibrationCountWidth'(CalibrationCycles - 1)) begin
				calibrationComplete <= 1'b1;
			end
			calibrationCount <= calibrationCount + 1'b1;
		end
	end

	// ----------------------------------------
	// Head decode
	// ----------------------------------------
	assign headIsRead = commands.headValid & (commands.command == CmdRead);
	assign headIsWrite = commands.headValid & (commands.command == CmdWrite);
	// Anything else is dropped
	assign headIsUnknown = commands.headValid & ~headIsRead & ~headIsWrite;

	// Write leaves only with a data beat beside it
	assign writeJoined = headIsWrite & writes.headValid;

	// ----------------------------------------
	// Pops, in order, nothing before calibration
	// ----------------------------------------
	// A waiting write blocks everything behind it
	assign commands.pop = calibrationComplete & (headIsRead | writeJoined | headIsUnknown);
	// Data queue pops together with its command
	assign writes.pop = calibrationComplete & writeJoined;

	// ----------------------------------------
	// Access strobe to the array
	// ----------------------------------------
	assign access.enable = calibrationComplete & (headIsRead | writeJoined);
	assign access.isWrite = headIsWrite;
	assign access.address = commands.address;
	assign access.data = writes.data;
	assign access.mask = writes.mask;

endmodule
`default_nettype wire

// ==== maskedMemoryArray.sv ====
`default_nettype none
`timescale 1ns/1ps
// ----------------------------------------
// Masked word array
// Byte-lane masked writes, registered reads
// ----------------------------------------
module maskedMemoryArray import dramPkg::*; (
	input logic MemoryClock,
	memAccessIf.sink access,
	output logic readStrobe,
	output logic [DataWidth-1:0] readWord
);

	// Contents undefined at power-up like real DRAM
	logic [DataWidth-1:0] words [MemoryWords];

	// ----------------------------------------
	// Masked write
	// ----------------------------------------
	always_ff @(posedge MemoryClock) begin
		if (access.enable && access.isWrite) begin
			for (int lane = 0; lane < MaskWidth; lane++) begin
				// Mask bit 1 keeps the old byte
				if (!access.mask[lane]) begin
					words[access.address][lane*ByteWidth +: ByteWidth] <=
						access.data[lane*ByteWidth +: ByteWidth];
				end
			end
		end
	end

	// ----------------------------------------
	// Registered read
	// ----------------------------------------
	// Word sampled at the issue edge
	always_ff @(posedge MemoryClock) begin
		if (access.enable && !access.isWrite) begin
			readWord <= words[access.address];
		end
	end

	// One-cycle strobe for each read
	always_ff @(posedge MemoryClock) begin
		readStrobe <= access.enable & ~access.isWrite;
	end

endmodule
`default_nettype wire

// ==== readReturnPipe.sv ====
`default_nettype none
`timescale 1ns/1ps
// ----------------------------------------
// Read return pipe
// Fixed-latency in-order delay for read results
// ----------------------------------------
module readReturnPipe import dramPkg::*; (
	input logic MemoryClock,
	input logic rstN,
	input logic readStrobe,
	input logic [DataWidth-1:0] readWord,
	output logic [DataWidth-1:0] readData,
	output logic readDataValid
);

	// Array register is the first stage of ReadLatency
	logic [ReturnStages-1:0] validStages;
	logic [DataWidth-1:0] dataStages [ReturnStages];

	// Valid shift, cleared by reset
	always_ff @(posedge MemoryClock or negedge rstN) begin
		if (!rstN) begin
			validStages <= '0;
		end else begin
			validStages <= {validStages[ReturnStages-2:0], readStrobe};
		end
	end

	// Data shift alongside the valids
	always_ff @(posedge MemoryClock) begin
		dataStages[0] <= readWord;
		for (int stage = 1; stage < ReturnStages; stage++) begin
			dataStages[stage] <= dataStages[stage-1];
		end
	end

	// Last stage drives the user port
	assign readDataValid = validStages[ReturnStages-1];
	assign readData = dataStages[ReturnStages-1];

endmodule
`default_nettype wire

// ==== dramSubsystemTop.sv ====
`default_nettype none
`timescale 1ns/1ps
// ----------------------------------------
// DRAM user-port subsystem top
// Queues, scheduler, array and return pipe
// ----------------------------------------
module dramSubsystemTop import dramPkg::*; (
	input logic MemoryClock,
	input logic rstN,

	// Command channel
	input logic [AddressWidth-1:0] DramAddress,
	input logic [CommandWidth-1:0] DramCommand,
	input logic DramCommandValid,
	output logic DramCommandReady,

	// Write data channel
	input logic [DataWidth-1:0] DramWriteData,
	input logic [MaskWidth-1:0] DramWriteMask,
	input logic DramWriteDataValid,
	output logic DramWriteDataReady,

	// Read return, no ready
	output logic [DataWidth-1:0] DramReadData,
	output logic DramReadDataValid,

	output logic CalibrationComplete
);

	// ----------------------------------------
	// Internal buses
	// ----------------------------------------
	memCommandIf commandHead ();
	memWriteIf writeHead ();
	memAccessIf arrayAccess ();

	logic readStrobe;
	logic [DataWidth-1:0] readWord;

	// ----------------------------------------
	// Input queues
	// ----------------------------------------
	commandQueue commandQueue0 (
		.MemoryClock(MemoryClock), .rstN(rstN),
		.command(DramCommand), .address(DramAddress),
		.valid(DramCommandValid), .ready(DramCommandReady),
		.head(commandHead)
	);

	writeDataQueue writeDataQueue0 (
		.MemoryClock(MemoryClock), .rstN(rstN),
		.data(DramWriteData), .mask(DramWriteMask),
		.valid(DramWriteDataValid), .ready(DramWriteDataReady),
		.head(writeHead)
	);

	// ----------------------------------------
	// Issue, storage, return
	// ----------------------------------------
	accessScheduler accessScheduler0 (
		.MemoryClock(MemoryClock), .rstN(rstN),
		.commands(commandHead), .writes(writeHead),
		.access(arrayAccess), .calibrationComplete(CalibrationComplete)
	);

	maskedMemoryArray maskedMemoryArray0 (
		.MemoryClock(MemoryClock), .access(arrayAccess),
		.readStrobe(readStrobe), .readWord(readWord)
	);

	readReturnPipe readReturnPipe0 (
		.MemoryClock(MemoryClock), .rstN(rstN),
		.readStrobe(readStrobe), .readWord(readWord),
		.readData(DramReadData), .readDataValid(DramReadDataValid)
	);

endmodule
`default_nettype wire

// ==== dramSubsystem_assertions.sv ====
`default_nettype none
`timescale 1ns/1ps
// ----------------------------------------
// Status and read-return properties of the subsystem top
// ----------------------------------------
module dramSubsystemAssertions (
	input logic MemoryClock,
	input logic rstN,
	input logic CalibrationComplete,
	input logic DramReadDataValid,
	input logic DramCommandReady,
	input logic DramWriteDataValid
);

	logic [3:0] stalledCycles;

	// Cycles of command ready low with write data on hand
	always_ff @(posedge MemoryClock or negedge rstN) begin
		if (!rstN) begin
			stalledCycles <= '0;
		end else if (CalibrationComplete && DramWriteDataValid && !DramCommandReady) begin
			stalledCycles <= stalledCycles + 1'b1;
		end else begin
			stalledCycles <= '0;
		end
	end

	// Calibration is one-way
	calibrationStays: assert property (@(posedge MemoryClock) disable iff (!rstN)
		CalibrationComplete |=> CalibrationComplete)
		else $error("CalibrationComplete fell after rising");

	// No read data before calibration
	noEarlyRead: assert property (@(posedge MemoryClock) disable iff (!rstN)
		!CalibrationComplete |-> !DramReadDataValid)
		else $error("DramReadDataValid high before calibration");

	// Data on hand lets a waiting write drain
	commandReadyReturns: assert property (@(posedge MemoryClock) disable iff (!rstN)
		stalledCycles < 4'd8)
		else $error("DramCommandReady stuck low with write data offered");

endmodule

bind dramSubsystemTop dramSubsystemAssertions assertions0 (
	.MemoryClock(MemoryClock),
	.rstN(rstN),
	.CalibrationComplete(CalibrationComplete),
	.DramReadDataValid(DramReadDataValid),
	.DramCommandReady(DramCommandReady),
	.DramWriteDataValid(DramWriteDataValid)
);
`default_nettype wire

// ==== tbDramSubsystem.sv ====
`default_nettype none
`timescale 1ns/1ps
// ----------------------------------------
// Testbench for the DRAM user-port subsystem
// Table-driven commands, reference memory, in-order read checks
// ----------------------------------------
module tbDramSubsystem import dramPkg::*; ();

	// Write data timing against its command
	localparam int ModeBefore = 0;
	localparam int ModeWith = 1;
	localparam int ModeAfter = 2;
	localparam int TableLength = 22;
	localparam int MaxGap = 2;
	localparam int MaxDataDelay = 10;
	localparam int TimeoutCycles = CalibrationCycles +
		TableLength * (MaxGap + MaxDataDelay + ReadLatency + 4) + 50;

	typedef struct {
		logic [CommandWidth-1:0] command;
		logic [AddressWidth-1:0] address;
		logic [DataWidth-1:0] data;
		logic [MaskWidth-1:0] mask;
		int dataMode;
		int dataDelay;
		bit randomGap;
		bit expectRead;
	} entryT;

	logic MemoryClock;
	logic rstN;
	logic [AddressWidth-1:0] DramAddress;
	logic [CommandWidth-1:0] DramCommand;
	logic DramCommandValid;
	logic DramCommandReady;
	logic [DataWidth-1:0] DramWriteData;
	logic [MaskWidth-1:0] DramWriteMask;
	logic DramWriteDataValid;
	logic DramWriteDataReady;
	logic [DataWidth-1:0] DramReadData;
	logic DramReadDataValid;
	logic CalibrationComplete;

	entryT stimulusTable [TableLength];
	logic [DataWidth-1:0] refMem [MemoryWords];
	logic [DataWidth-1:0] expectedReads [$];
	// Beats waiting for the data driver
	logic [DataWidth-1:0] pendingData [$];
	logic [MaskWidth-1:0] pendingMask [$];
	int pendingRelease [$];
	int beatsQueued = 0;
	int beatsAccepted = 0;
	int cycleCount = 0;
	int releaseEdges = 0;
	int valueErrors = 0;
	int otherErrors = 0;
	bit calibrationSeen = 0;
	bit sawCommandFull = 0;
	bit dataReadyAtDrive = 0;

	dramSubsystemTop dut0 (.*);

	initial begin
		MemoryClock = 1'b0;
		forever #20 MemoryClock = ~MemoryClock;
	end

	// ----------------------------------------
	// Cycle counter and timeout
	// ----------------------------------------
	initial begin
		while (cycleCount <= TimeoutCycles) begin
			@(posedge MemoryClock);
			cycleCount++;
			if (rstN) releaseEdges++;
			// Beat handshake seen at the edge
			if (DramWriteDataValid && DramWriteDataReady) beatsAccepted++;
		end
		$display("Timeout after %0d cycles, reads still outstanding: %0d",
			cycleCount, expectedReads.size());
		$display("Test failures found");
		$finish;
	end

	// Byte lanes with mask bit 0 take the new byte
	function automatic logic [DataWidth-1:0] mergeBytes(input logic [DataWidth-1:0] oldWord,
			input logic [DataWidth-1:0] newWord, input logic [MaskWidth-1:0] laneMask);
		logic [DataWidth-1:0] merged;
		merged = oldWord;
		for (int lane = 0; lane < MaskWidth; lane++) begin
			if (!laneMask[lane]) merged[lane*8 +: 8] = newWord[lane*8 +: 8];
		end
		return merged;
	endfunction

	function automatic entryT makeEntry(input logic [CommandWidth-1:0] command,
			input logic [AddressWidth-1:0] address, input logic [DataWidth-1:0] data,
			input logic [MaskWidth-1:0] mask, input int dataMode, input int dataDelay,
			input bit randomGap);
		entryT e;
		e.command = command;
		e.address = address;
		e.data = data;
		e.mask = mask;
		e.dataMode = dataMode;
		e.dataDelay = dataDelay;
		e.randomGap = randomGap;
		e.expectRead = (command == CmdRead);
		return e;
	endfunction

	// ----------------------------------------
	// Stimulus table
	// ----------------------------------------
	task automatic buildTable();
		// Early writes land before calibration ends
		stimulusTable[0] = makeEntry(CmdWrite, 10'h010, 64'h0123_4567_89ab_cdef, 8'h00,
			ModeWith, 0, 1);
		stimulusTable[1] = makeEntry(CmdWrite, 10'h011, 64'hfeed_face_cafe_beef, 8'h00,
			ModeWith, 0, 1);
		stimulusTable[2] = makeEntry(CmdWrite, 10'h012, 64'h1111_2222_3333_4444, 8'h00,
			ModeBefore, 0, 1);
		stimulusTable[3] = makeEntry(CmdRead, 10'h010, '0, '0, ModeWith, 0, 0);
		stimulusTable[4] = makeEntry(CmdRead, 10'h011, '0, '0, ModeWith, 0, 0);
		stimulusTable[5] = makeEntry(CmdRead, 10'h012, '0, '0, ModeWith, 0, 1);
		// Partial mask merge
		stimulusTable[6] = makeEntry(CmdWrite, 10'h010, 64'haaaa_bbbb_cccc_dddd, 8'ha5,
			ModeWith, 0, 1);
		stimulusTable[7] = makeEntry(CmdRead, 10'h010, '0, '0, ModeWith, 0, 1);
		// Late data blocks the reads behind
		stimulusTable[8] = makeEntry(CmdWrite, 10'h020, 64'h5a5a_5a5a_a5a5_a5a5, 8'h00,
			ModeAfter, 6, 0);
		stimulusTable[9] = makeEntry(CmdRead, 10'h020, '0, '0, ModeWith, 0, 0);
		stimulusTable[10] = makeEntry(CmdRead, 10'h011, '0, '0, ModeWith, 0, 1);
		// Long stall while reads fill the command queue
		stimulusTable[11] = makeEntry(CmdWrite, 10'h021, 64'h0f0f_0f0f_f0f0_f0f0, 8'h00,
			ModeAfter, 10, 0);
		stimulusTable[12] = makeEntry(CmdRead, 10'h021, '0, '0, ModeWith, 0, 0);
		stimulusTable[13] = makeEntry(CmdRead, 10'h010, '0, '0, ModeWith, 0, 0);
		stimulusTable[14] = makeEntry(CmdRead, 10'h012, '0, '0, ModeWith, 0, 0);
		stimulusTable[15] = makeEntry(CmdRead, 10'h020, '0, '0, ModeWith, 0, 0);
		stimulusTable[16] = makeEntry(CmdRead, 10'h011, '0, '0, ModeWith, 0, 0);
		stimulusTable[17] = makeEntry(CmdRead, 10'h021, '0, '0, ModeWith, 0, 1);
		// Unknown codes are dropped without data
		stimulusTable[18] = makeEntry(3'd5, 10'h012, 64'hdead_dead_dead_dead, 8'h00,
			ModeWith, 0, 1);
		stimulusTable[19] = makeEntry(3'd7, 10'h010, 64'hbad0_bad0_bad0_bad0, 8'h00,
			ModeWith, 0, 1);
		stimulusTable[20] = makeEntry(CmdRead, 10'h012, '0, '0, ModeWith, 0, 0);
		stimulusTable[21] = makeEntry(CmdRead, 10'h010, '0, '0, ModeWith, 0, 1);
	endtask

	task automatic queueBeat(input logic [DataWidth-1:0] data, input logic [MaskWidth-1:0] mask,
			input int releaseCycle);
		pendingData.push_back(data);
		pendingMask.push_back(mask);
		pendingRelease.push_back(releaseCycle);
		beatsQueued++;
	endtask

	// Holds valid until ready seen at a falling edge
	task automatic sendCommand(input logic [CommandWidth-1:0] command,
			input logic [AddressWidth-1:0] address);
		@(negedge MemoryClock);
		DramCommand = command;
		DramAddress = address;
		DramCommandValid = 1'b1;
		while (!DramCommandReady) begin
			sawCommandFull = 1'b1;
			@(negedge MemoryClock);
		end
	endtask

	task automatic idleCycles(input int count);
		if (count > 0) begin
			@(negedge MemoryClock);
			DramCommandValid = 1'b0;
			repeat (count - 1) @(negedge MemoryClock);
		end
	endtask

	task automatic applyEntry(input entryT e);
		int gap;
		gap = e.randomGap ? int'($urandom % (MaxGap + 1)) : 0;
		if (e.command == CmdWrite) begin
			if (e.dataMode == ModeBefore) begin
				queueBeat(e.data, e.mask, cycleCount + 1);
				idleCycles(1);
				while (beatsAccepted != beatsQueued) @(negedge MemoryClock);
			end else if (e.dataMode == ModeAfter) begin
				queueBeat(e.data, e.mask, cycleCount + 1 + e.dataDelay);
			end else begin
				queueBeat(e.data, e.mask, cycleCount + 1);
			end
			refMem[e.address] = mergeBytes(refMem[e.address], e.data, e.mask);
		end
		if (e.expectRead) expectedReads.push_back(refMem[e.address]);
		sendCommand(e.command, e.address);
		idleCycles(gap);
	endtask

	// ----------------------------------------
	// Write data driver in queue order
	// ----------------------------------------
	initial begin
		@(posedge rstN);
		forever begin
			@(negedge MemoryClock);
			if (!DramWriteDataValid || dataReadyAtDrive) begin
				if (pendingData.size() > 0 && pendingRelease[0] <= cycleCount) begin
					DramWriteData = pendingData.pop_front();
					DramWriteMask = pendingMask.pop_front();
					void'(pendingRelease.pop_front());
					DramWriteDataValid = 1'b1;
				end else begin
					DramWriteDataValid = 1'b0;
				end
			end
			dataReadyAtDrive = DramWriteDataReady;
		end
	end

	// ----------------------------------------
	// Read return and calibration monitor
	// ----------------------------------------
	initial begin
		@(posedge rstN);
		forever begin
			@(negedge MemoryClock);
			if (CalibrationComplete && !calibrationSeen) begin
				calibrationSeen = 1'b1;
				assert (releaseEdges == CalibrationCycles) else begin
					$display("CHECK FAILED at %0t: CalibrationComplete edges expected %0d got %0d",
						$time, CalibrationCycles, releaseEdges);
					valueErrors++;
				end
			end
			if (DramReadDataValid) begin
				if (!CalibrationComplete) begin
					$display("Read data returned before calibration ended at %0t", $time);
					otherErrors++;
				end
				if (expectedReads.size() == 0) begin
					$display("Unexpected read result at %0t with no read outstanding", $time);
					otherErrors++;
				end else begin
					logic [DataWidth-1:0] expected;
					expected = expectedReads.pop_front();
					assert (DramReadData === expected) else begin
						$display("CHECK FAILED at %0t: DramReadData expected %h got %h",
							$time, expected, DramReadData);
						valueErrors++;
					end
				end
			end
		end
	end

	// ----------------------------------------
	// Main sequence
	// ----------------------------------------
	initial begin
		void'($urandom(7247));
		rstN = 1'b0;
		DramAddress = '0;
		DramCommand = '0;
		DramCommandValid = 1'b0;
		DramWriteData = '0;
		DramWriteMask = '0;
		DramWriteDataValid = 1'b0;
		buildTable();
		repeat (5) @(negedge MemoryClock);
		rstN = 1'b1;
		// State right after reset
		assert (DramCommandReady && DramWriteDataReady && !DramReadDataValid &&
				!CalibrationComplete) else begin
			$display("Outputs after reset are wrong: readys not high or status not low");
			otherErrors++;
		end
		for (int i = 0; i < TableLength; i++) applyEntry(stimulusTable[i]);
		idleCycles(1);
		while (expectedReads.size() > 0 || pendingData.size() > 0) @(negedge MemoryClock);
		// Room for any stray result
		repeat (ReadLatency + 4) @(negedge MemoryClock);
		assert (sawCommandFull) else begin
			$display("DramCommandReady never dropped while the command queue was full");
			otherErrors++;
		end
		assert (calibrationSeen) else begin
			$display("CalibrationComplete never rose");
			otherErrors++;
		end
		$display("Errors: value %0d, other %0d", valueErrors, otherErrors);
		if (valueErrors == 0 && otherErrors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule
`default_nettype wire

// ==== dramSubsystem.f ====
dramPkg.sv
dramIfs.sv
commandQueue.sv
writeDataQueue.sv
accessScheduler.sv
maskedMemoryArray.sv
readReturnPipe.sv
dramSubsystemTop.sv
dramSubsystem_assertions.sv
tbDramSubsystem.sv

// ==== Makefile ====
# Verilator build and run for the DRAM subsystem testbench

TOP := tbDramSubsystem

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f dramSubsystem.f \
		--top-module $(TOP) -o simDram

# Pass only when the pass message shows up
run: build
	./obj_dir/simDram | tee /dev/stderr | grep -q "All tests passed!"

lint:
	verilator --lint-only --timing --assert -f dramSubsystem.f \
		--top-module $(TOP)

clean:
	rm -rf obj_dir
